// File: logic/noc_defines.svh
// ################################################
// NoC size defines
// Tile count, flit width and header field layout
// for the 2x2 mesh network
// ################################################

`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// Four tiles in a fixed 2x2 mesh
`define NOC_NUM_TILES 4

// Router ports: local, x neighbour, y neighbour
`define NOC_NUM_PORTS 3

// Flit payload width
`define NOC_DATA_W 32

// Tile id is {y, x}, one bit each
`define NOC_TILE_W 2

// Header flit layout, dest in 31:30 and src in 29:28
`define NOC_HDR_DEST_LSB 30
`define NOC_HDR_SRC_LSB 28

`endif

// File: logic/noc_pkg.sv
// ################################################
// NoC types
// Link flit, client message and router port
// encoding shared by the mesh blocks
// ################################################

`include "noc_defines.svh"

package noc_pkg;

   // One flit on a mesh link
   // Last marks the final flit of a packet
   typedef struct packed {
      logic                   last;
      logic [`NOC_DATA_W-1:0] data;
   } noc_flit_t;

   // Client message between a tile and its adapter
   // Tile is the destination when sending, the source when receiving
   typedef struct packed {
      logic [`NOC_TILE_W-1:0] tile;
      logic [`NOC_DATA_W-1:0] data;
   } noc_msg_t;

   // Router port index
   // Also the order used by the round-robin arbiters
   typedef enum logic [1:0] {
      PORT_LOCAL = 2'd0,
      PORT_X     = 2'd1,
      PORT_Y     = 2'd2
   } noc_port_e;

endpackage

// File: logic/noc_router.sv
// ################################################
// Three-port mesh router
// One-entry input registers, XY route selection
// and per-output round-robin arbitration that
// stays locked from header to last flit
// ################################################

`include "noc_defines.svh"

module noc_router #(
   parameter int TILE_ID = 0
) (
   input  logic                                     clk,
   input  logic                                     reset_i,
   input  noc_pkg::noc_flit_t [`NOC_NUM_PORTS-1:0] in_flit_i,
   input  logic [`NOC_NUM_PORTS-1:0]                in_valid_i,
   output logic [`NOC_NUM_PORTS-1:0]                in_ready_o,
   output noc_pkg::noc_flit_t [`NOC_NUM_PORTS-1:0] out_flit_o,
   output logic [`NOC_NUM_PORTS-1:0]                out_valid_o,
   input  logic [`NOC_NUM_PORTS-1:0]                out_ready_i
);

   localparam int NP = `NOC_NUM_PORTS;
   localparam logic [`NOC_TILE_W-1:0] MY_ID = `NOC_TILE_W'(TILE_ID);

   // Input registers
   noc_pkg::noc_flit_t [NP-1:0] buf_q;
   logic [NP-1:0]               full_q;
   noc_pkg::noc_port_e          route_q [NP];
   logic [NP-1:0]               push;
   logic [NP-1:0]               pop;

   // Per-output arbitration, req[o][i] is input i asking for output o
   logic [NP-1:0]               req [NP];
   noc_pkg::noc_port_e          grant [NP];
   logic [NP-1:0]               grant_vld;
   logic [NP-1:0]               fire;
   logic [NP-1:0]               locked_q;
   noc_pkg::noc_port_e          owner_q [NP];
   noc_pkg::noc_port_e          rr_q [NP];

   // XY routing, correct x first, then y
   function automatic noc_pkg::noc_port_e xy_route(input logic [`NOC_TILE_W-1:0] dest);
      noc_pkg::noc_port_e port;
      if (dest[0] != MY_ID[0]) begin
         port = noc_pkg::PORT_X;
      end else if (dest[1] != MY_ID[1]) begin
         port = noc_pkg::PORT_Y;
      end else begin
         port = noc_pkg::PORT_LOCAL;
      end
      return port;
   endfunction

   // Turns that XY routing can take in a 2x2 mesh
   // X input never goes back to X, Y input only ejects
   // Keeps the ready paths between neighbours free of loops
   function automatic logic turn_ok(input int src, input int dst);
      logic ok;
      case (src)
         noc_pkg::PORT_X: ok = (dst != noc_pkg::PORT_X);
         noc_pkg::PORT_Y: ok = (dst == noc_pkg::PORT_LOCAL);
         default:         ok = 1'b1;
      endcase
      return ok;
   endfunction

   // Round-robin successor of a port
   function automatic noc_pkg::noc_port_e next_port(input noc_pkg::noc_port_e p);
      noc_pkg::noc_port_e n;
      case (p)
         noc_pkg::PORT_LOCAL: n = noc_pkg::PORT_X;
         noc_pkg::PORT_X:     n = noc_pkg::PORT_Y;
         default:             n = noc_pkg::PORT_LOCAL;
      endcase
      return n;
   endfunction

   // Request matrix from the held route of each full input
   always_comb begin
      for (int o = 0; o < NP; o++) begin
         for (int i = 0; i < NP; i++) begin
            req[o][i] = full_q[i] && (route_q[i] == noc_pkg::noc_port_e'(o))
                        && turn_ok(i, o);
         end
      end
   end

   // Grant selection
   // Locked output follows its owner, otherwise search from the pointer
   always_comb begin
      noc_pkg::noc_port_e cand;
      cand = noc_pkg::PORT_LOCAL;
      for (int o = 0; o < NP; o++) begin
         grant[o]     = rr_q[o];
         grant_vld[o] = 1'b0;
         if (locked_q[o]) begin
            grant[o]     = owner_q[o];
            grant_vld[o] = req[o][owner_q[o]];
         end else begin
            cand = rr_q[o];
            for (int k = 0; k < NP; k++) begin
               if (!grant_vld[o] && req[o][cand]) begin
                  grant[o]     = cand;
                  grant_vld[o] = 1'b1;
               end
               cand = next_port(cand);
            end
         end
      end
   end

   // Output mux straight from the granted input register
   always_comb begin
      for (int o = 0; o < NP; o++) begin
         out_valid_o[o] = grant_vld[o];
         out_flit_o[o]  = buf_q[grant[o]];
         fire[o]        = grant_vld[o] && out_ready_i[o];
      end
   end

   // An input empties when its granted output transfers
   always_comb begin
      pop = '0;
      for (int o = 0; o < NP; o++) begin
         if (fire[o]) begin
            pop[grant[o]] = 1'b1;
         end
      end
   end

   // Ready when empty or emptying this cycle
   assign in_ready_o = ~full_q | pop;
   assign push       = in_valid_i & in_ready_o;

   // Occupancy of the input registers
   always_ff @(posedge clk) begin
      if (reset_i) begin
         full_q <= '0;
      end else begin
         for (int p = 0; p < NP; p++) begin
            if (push[p]) begin
               full_q[p] <= 1'b1;
            end else if (pop[p]) begin
               full_q[p] <= 1'b0;
            end
         end
      end
   end

   // Flit capture
   // Route is taken from the header and kept for the payload
   always_ff @(posedge clk) begin
      for (int p = 0; p < NP; p++) begin
         if (push[p]) begin
            buf_q[p] <= in_flit_i[p];
            if (!in_flit_i[p].last) begin
               route_q[p] <= xy_route(in_flit_i[p].data[`NOC_HDR_DEST_LSB +: `NOC_TILE_W]);
            end
         end
      end
   end

   // Arbiter state
   // Lock as soon as a flit is offered so a stalled flit stays put
   // Release and advance the pointer when the last flit leaves
   always_ff @(posedge clk) begin
      if (reset_i) begin
         for (int o = 0; o < NP; o++) begin
            locked_q[o] <= 1'b0;
            owner_q[o]  <= noc_pkg::PORT_LOCAL;
            rr_q[o]     <= noc_pkg::PORT_LOCAL;
         end
      end else begin
         for (int o = 0; o < NP; o++) begin
            if (grant_vld[o]) begin
               if (fire[o] && out_flit_o[o].last) begin
                  locked_q[o] <= 1'b0;
                  rr_q[o]     <= next_port(grant[o]);
               end else begin
                  locked_q[o] <= 1'b1;
                  owner_q[o]  <= grant[o];
               end
            end
         end
      end
   end

endmodule

// File: logic/noc_adapter.sv
// ################################################
// Tile network adapter
// Packs a client message into header and payload
// flits, unpacks arriving packets into a strobe
// ################################################

`include "noc_defines.svh"

module noc_adapter #(
   parameter int TILE_ID = 0
) (
   input  logic               clk,
   input  logic               reset_i,
   input  logic               send_valid_i,
   input  noc_pkg::noc_msg_t  send_msg_i,
   output logic               send_busy_o,
   output logic               recv_valid_o,
   output noc_pkg::noc_msg_t  recv_msg_o,
   output noc_pkg::noc_flit_t net_out_flit_o,
   output logic               net_out_valid_o,
   input  logic               net_out_ready_i,
   input  noc_pkg::noc_flit_t net_in_flit_i,
   input  logic               net_in_valid_i,
   output logic               net_in_ready_o
);

   localparam logic [`NOC_TILE_W-1:0] MY_ID = `NOC_TILE_W'(TILE_ID);

   typedef enum logic [1:0] {
      IDLE,
      HDR,
      PAYLOAD
   } send_state_e;

   send_state_e            state_q;
   noc_pkg::noc_msg_t      send_q;
   logic                   send_take;
   logic                   rx_take;
   logic [`NOC_TILE_W-1:0] rx_src_q;
   logic                   recv_valid_q;
   noc_pkg::noc_msg_t      recv_q;

   // Send path
   assign send_busy_o     = (state_q != IDLE);
   assign net_out_valid_o = (state_q != IDLE);
   assign send_take       = send_valid_i && !send_busy_o;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q <= IDLE;
      end else begin
         case (state_q)
            IDLE:    if (send_take) state_q <= HDR;
            HDR:     if (net_out_ready_i) state_q <= PAYLOAD;
            PAYLOAD: if (net_out_ready_i) state_q <= IDLE;
            default: state_q <= IDLE;
         endcase
      end
   end

   // Message held until the payload flit is gone
   always_ff @(posedge clk) begin
      if (send_take) begin
         send_q <= send_msg_i;
      end
   end

   // Header carries dest and own id, payload carries the word
   always_comb begin
      net_out_flit_o = '0;
      case (state_q)
         HDR: begin
            net_out_flit_o.data[`NOC_HDR_DEST_LSB +: `NOC_TILE_W] = send_q.tile;
            net_out_flit_o.data[`NOC_HDR_SRC_LSB +: `NOC_TILE_W]  = MY_ID;
         end
         PAYLOAD: begin
            net_out_flit_o.last = 1'b1;
            net_out_flit_o.data = send_q.data;
         end
         default: ;
      endcase
   end

   // Receive path, always ready
   assign net_in_ready_o = 1'b1;
   assign rx_take        = net_in_valid_i && net_in_ready_o;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         recv_valid_q <= 1'b0;
      end else begin
         recv_valid_q <= rx_take && net_in_flit_i.last;
      end
   end

   // Source from the header, word from the last flit
   always_ff @(posedge clk) begin
      if (rx_take) begin
         if (!net_in_flit_i.last) begin
            rx_src_q <= net_in_flit_i.data[`NOC_HDR_SRC_LSB +: `NOC_TILE_W];
         end else begin
            recv_q.tile <= rx_src_q;
            recv_q.data <= net_in_flit_i.data;
         end
      end
   end

   assign recv_valid_o = recv_valid_q;
   assign recv_msg_o   = recv_q;

endmodule

// File: logic/system_2x2_dm.sv
// ################################################
// 2x2 mesh system top
// Four tiles, each an adapter on the local port
// of a three-port XY router
// ################################################

`include "noc_defines.svh"

module system_2x2_dm (
   input  logic                                    clk,
   input  logic                                    reset_i,
   input  logic [`NOC_NUM_TILES-1:0]               send_valid_i,
   input  noc_pkg::noc_msg_t [`NOC_NUM_TILES-1:0] send_msg_i,
   output logic [`NOC_NUM_TILES-1:0]               send_busy_o,
   output logic [`NOC_NUM_TILES-1:0]               recv_valid_o,
   output noc_pkg::noc_msg_t [`NOC_NUM_TILES-1:0] recv_msg_o
);

   localparam int NT = `NOC_NUM_TILES;
   localparam int NP = `NOC_NUM_PORTS;

   // Link signals seen from each router, indexed [tile][port]
   noc_pkg::noc_flit_t [NP-1:0] rt_in_flit [NT];
   logic [NP-1:0]               rt_in_valid [NT];
   logic [NP-1:0]               rt_in_ready [NT];
   noc_pkg::noc_flit_t [NP-1:0] rt_out_flit [NT];
   logic [NP-1:0]               rt_out_valid [NT];
   logic [NP-1:0]               rt_out_ready [NT];

   for (genvar t = 0; t < NT; t++) begin : gen_tile
      // Neighbour ids, id bit 0 is x and bit 1 is y
      localparam int NX = t ^ 1;
      localparam int NY = t ^ 2;

      // Adapter on the local port
      noc_adapter #(
         .TILE_ID (t)
      ) u_na (
         .clk             (clk),
         .reset_i         (reset_i),
         .send_valid_i    (send_valid_i[t]),
         .send_msg_i      (send_msg_i[t]),
         .send_busy_o     (send_busy_o[t]),
         .recv_valid_o    (recv_valid_o[t]),
         .recv_msg_o      (recv_msg_o[t]),
         .net_out_flit_o  (rt_in_flit[t][noc_pkg::PORT_LOCAL]),
         .net_out_valid_o (rt_in_valid[t][noc_pkg::PORT_LOCAL]),
         .net_out_ready_i (rt_in_ready[t][noc_pkg::PORT_LOCAL]),
         .net_in_flit_i   (rt_out_flit[t][noc_pkg::PORT_LOCAL]),
         .net_in_valid_i  (rt_out_valid[t][noc_pkg::PORT_LOCAL]),
         .net_in_ready_o  (rt_out_ready[t][noc_pkg::PORT_LOCAL])
      );

      // X link from the neighbour across x
      assign rt_in_flit[t][noc_pkg::PORT_X]    = rt_out_flit[NX][noc_pkg::PORT_X];
      assign rt_in_valid[t][noc_pkg::PORT_X]   = rt_out_valid[NX][noc_pkg::PORT_X];
      assign rt_out_ready[NX][noc_pkg::PORT_X] = rt_in_ready[t][noc_pkg::PORT_X];

      // Y link from the neighbour across y
      assign rt_in_flit[t][noc_pkg::PORT_Y]    = rt_out_flit[NY][noc_pkg::PORT_Y];
      assign rt_in_valid[t][noc_pkg::PORT_Y]   = rt_out_valid[NY][noc_pkg::PORT_Y];
      assign rt_out_ready[NY][noc_pkg::PORT_Y] = rt_in_ready[t][noc_pkg::PORT_Y];

      noc_router #(
         .TILE_ID (t)
      ) u_router (
         .clk         (clk),
         .reset_i     (reset_i),
         .in_flit_i   (rt_in_flit[t]),
         .in_valid_i  (rt_in_valid[t]),
         .in_ready_o  (rt_in_ready[t]),
         .out_flit_o  (rt_out_flit[t]),
         .out_valid_o (rt_out_valid[t]),
         .out_ready_i (rt_out_ready[t])
      );
   end

endmodule

// File: dv/system_2x2_props.sv
// ################################################
// 2x2 mesh protocol checks
// Reset state, client strobes, message integrity
// and valid/ready/last rules on every link
// ################################################

`include "noc_defines.svh"

module system_2x2_props (
   input logic                                     clk,
   input logic                                     reset_i,
   input logic [`NOC_NUM_TILES-1:0]                send_valid_i,
   input logic [`NOC_NUM_TILES-1:0]                send_busy_i,
   input logic [`NOC_NUM_TILES-1:0]                recv_valid_i,
   input noc_pkg::noc_msg_t [`NOC_NUM_TILES-1:0]  recv_msg_i,
   input noc_pkg::noc_flit_t [`NOC_NUM_PORTS-1:0] rt_in_flit_i [`NOC_NUM_TILES],
   input logic [`NOC_NUM_PORTS-1:0]                rt_in_valid_i [`NOC_NUM_TILES],
   input logic [`NOC_NUM_PORTS-1:0]                rt_in_ready_i [`NOC_NUM_TILES],
   input noc_pkg::noc_flit_t [`NOC_NUM_PORTS-1:0] rt_out_flit_i [`NOC_NUM_TILES],
   input logic [`NOC_NUM_PORTS-1:0]                rt_out_valid_i [`NOC_NUM_TILES],
   input logic [`NOC_NUM_PORTS-1:0]                rt_out_ready_i [`NOC_NUM_TILES]
);

   localparam int NT = `NOC_NUM_TILES;
   localparam int NP = `NOC_NUM_PORTS;
   // Three router outputs plus the adapter output per tile
   localparam int NL = NT * (NP + 1);

   noc_pkg::noc_flit_t [NL-1:0] link_flit;
   logic [NL-1:0]               link_valid;
   logic [NL-1:0]               link_ready;
   logic [NL-1:0]               link_fire;
   // High between a header transfer and its last flit
   logic [NL-1:0]               in_packet_q;

   // Flatten router outputs and adapter outputs into one link list
   always_comb begin
      for (int t = 0; t < NT; t++) begin
         for (int p = 0; p < NP; p++) begin
            link_flit[t*(NP+1)+p]  = rt_out_flit_i[t][p];
            link_valid[t*(NP+1)+p] = rt_out_valid_i[t][p];
            link_ready[t*(NP+1)+p] = rt_out_ready_i[t][p];
         end
         // Adapter drives the router local input
         link_flit[t*(NP+1)+NP]  = rt_in_flit_i[t][noc_pkg::PORT_LOCAL];
         link_valid[t*(NP+1)+NP] = rt_in_valid_i[t][noc_pkg::PORT_LOCAL];
         link_ready[t*(NP+1)+NP] = rt_in_ready_i[t][noc_pkg::PORT_LOCAL];
      end
   end

   assign link_fire = link_valid & link_ready;

   // Packet phase per link, flips on every transfer
   always_ff @(posedge clk) begin
      if (reset_i) begin
         in_packet_q <= '0;
      end else begin
         in_packet_q <= in_packet_q ^ link_fire;
      end
   end

   // Everything quiet from the first reset edge until traffic starts
   a_reset_quiet: assert property (@(posedge clk)
      reset_i |=> (send_busy_i == '0 && recv_valid_i == '0 && link_valid == '0))
      else $error("busy, receive strobe or link valid high after a reset edge");

   for (genvar t = 0; t < NT; t++) begin : gen_tile
      a_no_send_while_busy: assert property (@(posedge clk) disable iff (reset_i)
         send_busy_i[t] |-> !send_valid_i[t])
         else $error("tile %0d got a send strobe while busy", t);

      a_busy_after_send: assert property (@(posedge clk) disable iff (reset_i)
         (send_valid_i[t] && !send_busy_i[t]) |=> send_busy_i[t])
         else $error("tile %0d busy did not rise after an accepted send", t);

      // Word carries src in 31:30 and dest in 29:28
      a_recv_fields: assert property (@(posedge clk) disable iff (reset_i)
         recv_valid_i[t] |-> (recv_msg_i[t].tile == recv_msg_i[t].data[31:30]
                              && recv_msg_i[t].data[29:28] == 2'(t)))
         else $error("tile %0d received a message with wrong source or destination", t);
   end

   for (genvar l = 0; l < NL; l++) begin : gen_link
      // Header then last, never two of a kind in a row
      a_last_alternates: assert property (@(posedge clk) disable iff (reset_i)
         link_fire[l] |-> (link_flit[l].last == in_packet_q[l]))
         else $error("link %0d broke header and last alternation", l);

      a_hold_on_stall: assert property (@(posedge clk) disable iff (reset_i)
         (link_valid[l] && !link_ready[l]) |=> (link_valid[l] && $stable(link_flit[l])))
         else $error("link %0d dropped or changed a stalled flit", l);
   end

endmodule

// File: dv/tb_system_2x2.sv
// ################################################
// 2x2 mesh system testbench
// Pairwise delivery, contention on one tile and
// random traffic, checked by bound assertions
// and sent/received counts
// ################################################

`include "noc_defines.svh"

module tb_system_2x2;

   localparam int NT          = `NOC_NUM_TILES;
   localparam int PAIR_LIMIT  = 20;
   localparam int BUSY_LIMIT  = 100;
   localparam int DRAIN_LIMIT = 1000;
   localparam int NUM_RANDOM  = 200;

   logic                       clk;
   logic                       reset_i;
   logic [NT-1:0]              send_valid;
   noc_pkg::noc_msg_t [NT-1:0] send_msg;
   logic [NT-1:0]              send_busy;
   logic [NT-1:0]              recv_valid;
   noc_pkg::noc_msg_t [NT-1:0] recv_msg;

   int     sent_count;
   int     recv_count;
   int     seq;
   integer seed;
   int     src_tile;
   int     dst_tile;

   system_2x2_dm u_dut (
      .clk          (clk),
      .reset_i      (reset_i),
      .send_valid_i (send_valid),
      .send_msg_i   (send_msg),
      .send_busy_o  (send_busy),
      .recv_valid_o (recv_valid),
      .recv_msg_o   (recv_msg)
   );

   // Protocol checks see the top ports and the router links
   bind system_2x2_dm system_2x2_props u_props (
      .clk            (clk),
      .reset_i        (reset_i),
      .send_valid_i   (send_valid_i),
      .send_busy_i    (send_busy_o),
      .recv_valid_i   (recv_valid_o),
      .recv_msg_i     (recv_msg_o),
      .rt_in_flit_i   (rt_in_flit),
      .rt_in_valid_i  (rt_in_valid),
      .rt_in_ready_i  (rt_in_ready),
      .rt_out_flit_i  (rt_out_flit),
      .rt_out_valid_i (rt_out_valid),
      .rt_out_ready_i (rt_out_ready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Receive strobes, any number of tiles per cycle
   always_ff @(posedge clk) begin
      if (reset_i) begin
         recv_count <= 0;
      end else begin
         recv_count <= recv_count + $countones(recv_valid);
      end
   end

   task automatic stop_with_failure();
      $display("sim failed");
      $fatal(1, "run stopped at the first error");
   endtask

   // Data rule: src 31:30, dest 29:28, sequence below
   function automatic logic [`NOC_DATA_W-1:0] make_word(input int src, input int dst,
                                                        input int num);
      return {2'(src), 2'(dst), 28'(num)};
   endfunction

   // Called at 1 unit after an edge, returns the same way
   task automatic wait_idle(input int tile);
      int waited;
      waited = 0;
      while (send_busy[tile]) begin
         @(posedge clk);
         #1;
         waited++;
         if (waited > BUSY_LIMIT) begin
            $display("tile %0d stayed busy for %0d cycles", tile, waited);
            stop_with_failure();
         end
      end
   endtask

   // One-cycle send strobe
   task automatic send_one(input int src, input int dst);
      wait_idle(src);
      send_valid[src]    = 1'b1;
      send_msg[src].tile = 2'(dst);
      send_msg[src].data = make_word(src, dst, seq);
      @(posedge clk);
      #1;
      send_valid[src] = 1'b0;
      sent_count++;
      seq++;
   endtask

   task automatic wait_drain(input string name, input int limit);
      int waited;
      waited = 0;
      while (recv_count != sent_count) begin
         @(posedge clk);
         #1;
         waited++;
         if (waited > limit) begin
            $display("[ERROR] %s: expected %0d received, actual %0d", name, sent_count,
                     recv_count);
            stop_with_failure();
         end
      end
   endtask

   // Random choice among tiles that are not busy
   task automatic pick_idle_tile(output int tile);
      int idle_q[$];
      int waited;
      bit found;
      waited = 0;
      found  = 1'b0;
      while (!found) begin
         idle_q.delete();
         for (int t = 0; t < NT; t++) begin
            if (!send_busy[t]) idle_q.push_back(t);
         end
         if (idle_q.size() > 0) begin
            found = 1'b1;
         end else begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > BUSY_LIMIT) begin
               $display("no tile became idle within %0d cycles", BUSY_LIMIT);
               stop_with_failure();
            end
         end
      end
      tile = idle_q[$unsigned($random(seed)) % idle_q.size()];
   endtask

   initial begin
      seed       = 32'h4be0_0e92;
      sent_count = 0;
      seq        = 0;
      send_valid = '0;
      send_msg   = '0;
      reset_i    = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      reset_i = 1'b0;
      repeat (2) @(posedge clk);
      #1;

      // Every ordered pair, self-send included, one at a time
      for (int s = 0; s < NT; s++) begin
         for (int d = 0; d < NT; d++) begin
            send_one(s, d);
            wait_drain($sformatf("pair %0d to %0d", s, d), PAIR_LIMIT);
         end
      end

      // All tiles hit tile 3 in the same cycle
      for (int t = 0; t < NT; t++) wait_idle(t);
      for (int t = 0; t < NT; t++) begin
         send_valid[t]    = 1'b1;
         send_msg[t].tile = 2'(NT - 1);
         send_msg[t].data = make_word(t, NT - 1, seq + t);
      end
      @(posedge clk);
      #1;
      send_valid = '0;
      sent_count += NT;
      seq        += NT;
      wait_drain("contention on tile 3", NT * PAIR_LIMIT);

      // Random traffic, back to back where tiles are free
      for (int n = 0; n < NUM_RANDOM; n++) begin
         pick_idle_tile(src_tile);
         dst_tile = $unsigned($random(seed)) % NT;
         send_one(src_tile, dst_tile);
      end
      wait_drain("random traffic", DRAIN_LIMIT);

      // A few quiet cycles to catch stray strobes
      repeat (10) @(posedge clk);
      #1;
      if (recv_count != sent_count) begin
         $display("[ERROR] final count: expected %0d, actual %0d", sent_count, recv_count);
         stop_with_failure();
      end else begin
         $display("sim passed");
         $finish;
      end
   end

endmodule

// File: build.f
+incdir+logic
logic/noc_pkg.sv
logic/noc_router.sv
logic/noc_adapter.sv
logic/system_2x2_dm.sv
dv/system_2x2_props.sv
dv/tb_system_2x2.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the 2x2 mesh testbench with Verilator, run it and check the log

set -u -o pipefail

ROOT="$(cd "$(dirname "$0")" && pwd)"
cd "$ROOT" || exit 1

LOG=sim.log
BIN=obj_dir/Vtb_system_2x2

verilator --binary --assert -Wno-fatal --top-module tb_system_2x2 -f build.f
if [ $? -ne 0 ]; then
   echo "FAIL: verilator build error"
   exit 1
fi

"$BIN" 2>&1 | tee "$LOG"
run_status=${PIPESTATUS[0]}

if [ "$run_status" -ne 0 ]; then
   echo "FAIL: simulation exited with status $run_status"
   exit 1
fi

if grep -q "sim failed" "$LOG"; then
   echo "FAIL: failure reported in $LOG"
   exit 1
fi

if ! grep -qx "sim passed" "$LOG"; then
   echo "FAIL: simulation ended without a result in $LOG"
   exit 1
fi

echo "PASS"
exit 0
